/* list.f */
+incdir+bench
hw/ladder_pkg.sv
hw/mod_mul.sv
hw/mod_addsub.sv
hw/ladder_ctrl.sv
hw/ladder_ucode.sv
hw/ladder_datapath.sv
hw/ladder_top.sv
bench/ladder_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := ladder_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* bench/ladder_ref.svh */
/* Affine reference for the ladder testbench
   Field arithmetic and MSB-first double-and-add on the curve */
`ifndef LADDER_REF_SVH
`define LADDER_REF_SVH

localparam longint REF_P = longint'(FIELD_P);
localparam longint REF_A = longint'(CURVE_A);
localparam longint REF_B = longint'(CURVE_B);

function automatic longint field_mul(input longint a, input longint b);
	return (a * b) % REF_P;
endfunction

function automatic longint field_sub(input longint a, input longint b);
	return (a - b + REF_P) % REF_P;
endfunction

// Square and multiply, exponent LSB first
function automatic longint field_pow(input longint base, input longint e);
	longint r;
	longint b;
	r = 1;
	b = base % REF_P;
	while (e > 0) begin
		if (e % 2 == 1)
			r = field_mul(r, b);
		b = field_mul(b, b);
		e = e / 2;
	end
	return r;
endfunction

// Fermat inverse
function automatic longint field_inv(input longint a);
	return field_pow(a, REF_P - 2);
endfunction

// p = 3 mod 4 so one power gives the root
function automatic longint field_sqrt(input longint a);
	return field_pow(a, (REF_P + 1) / 4);
endfunction

function automatic void point_double(input longint x, input longint y, input logic inf,
	output longint rx, output longint ry, output logic rinf);
	longint lam;
	if (inf || y == 0) begin
		rx = 0;
		ry = 0;
		rinf = 1'b1;
	end else begin
		// Tangent slope (3x^2 + a) / 2y
		lam = field_mul((3 * field_mul(x, x) + REF_A) % REF_P, field_inv((2 * y) % REF_P));
		rx = field_sub(field_mul(lam, lam), (2 * x) % REF_P);
		ry = field_sub(field_mul(lam, field_sub(x, rx)), y);
		rinf = 1'b0;
	end
endfunction

function automatic void point_add(input longint x1, input longint y1, input logic i1,
	input longint x2, input longint y2, input logic i2,
	output longint rx, output longint ry, output logic rinf);
	longint lam;
	if (i1) begin
		rx = x2;
		ry = y2;
		rinf = i2;
	end else if (i2) begin
		rx = x1;
		ry = y1;
		rinf = 1'b0;
	end else if (x1 == x2) begin
		// Same x: either opposite points or a doubling
		if ((y1 + y2) % REF_P == 0) begin
			rx = 0;
			ry = 0;
			rinf = 1'b1;
		end else begin
			point_double(x1, y1, 1'b0, rx, ry, rinf);
		end
	end else begin
		lam = field_mul(field_sub(y2, y1), field_inv(field_sub(x2, x1)));
		rx = field_sub(field_sub(field_mul(lam, lam), x1), x2);
		ry = field_sub(field_mul(lam, field_sub(x1, rx)), y1);
		rinf = 1'b0;
	end
endfunction

// Affine x of k*P, or the infinity flag
function automatic void ref_mult(input logic [15:0] kv, input longint x, input longint y,
	output longint rx, output logic rinf);
	longint ax;
	longint ay;
	logic ainf;
	ax = 0;
	ay = 0;
	ainf = 1'b1;
	for (int i = 15; i >= 0; i--) begin
		point_double(ax, ay, ainf, ax, ay, ainf);
		if (kv[i])
			point_add(ax, ay, ainf, x, y, 1'b0, ax, ay, ainf);
	end
	rx = ax;
	rinf = ainf;
endfunction

`endif

/* bench/ladder_tb.sv */
/* Testbench for the ladder scalar multiplier
   Directed tests checked against an affine double-and-add model */
module ladder_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ladder_pkg::*;

	`include "ladder_ref.svh"

	// Transactions over all tests, sets the run limit
	localparam int NUM_TXN = 40;
	localparam int TIMEOUT_CYCLES = (NUM_TXN + 4) * (SCALAR_BITS * 20 + 50);

	logic    clk;
	logic    rst;
	logic    in_valid;
	logic    in_ready;
	logic    out_valid;
	logic    out_ready;
	scalar_t k;
	felem_t  px;
	felem_t  x_out;
	felem_t  z_out;
	int      errors;
	int      tests_run;
	int      tests_failed;

	ladder_top ladder_top_i (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .k(k), .px(px),
		.out_valid(out_valid), .out_ready(out_ready),
		.x_out(x_out), .z_out(z_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Run limit in clock cycles
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result from the DUT after %0d cycles", cycles);
		$display("sim failed");
		$finish;
	end

	// Offer a request, drop valid on the accepting edge
	task automatic send_req(input scalar_t kv, input felem_t pv);
		logic rdy;
		@(posedge clk);
		in_valid <= 1'b1;
		k <= kv;
		px <= pv;
		do begin
			@(negedge clk);
			rdy = in_ready;
			@(posedge clk);
		end while (!rdy);
		in_valid <= 1'b0;
	endtask

	// Wait for out_valid, stall for hold cycles, optionally offer the next request
	task automatic wait_result(input int hold, input logic offer, input scalar_t k2,
		input felem_t p2, output felem_t xr, output felem_t zr);
		felem_t x0;
		felem_t z0;
		do @(negedge clk); while (!out_valid);
		x0 = x_out;
		z0 = z_out;
		repeat (hold) begin
			@(posedge clk);
			if (offer) begin
				in_valid <= 1'b1;
				k <= k2;
				px <= p2;
			end
			@(negedge clk);
			if (x_out !== x0 || z_out !== z0) begin
				$display("[FAIL] %0t: result moved under stall, x %0d->%0d z %0d->%0d",
					$time, x0, x_out, z0, z_out);
				errors++;
			end
			if (in_ready !== 1'b0 || out_valid !== 1'b1) begin
				$display("[FAIL] %0t: stall handshake in_ready=%b out_valid=%b",
					$time, in_ready, out_valid);
				errors++;
			end
		end
		@(posedge clk);
		out_ready <= 1'b1;
		@(posedge clk);
		out_ready <= 1'b0;
		// Stalled offer withdrawn as the result is taken
		if (offer)
			in_valid <= 1'b0;
		xr = x0;
		zr = z0;
	endtask

	// Projective result against the affine model
	task automatic check_mult(input scalar_t kv, input felem_t pxv, input felem_t pyv,
		input felem_t xr, input felem_t zr);
		longint ex;
		longint ax;
		logic   einf;
		ref_mult(kv, pxv, pyv, ex, einf);
		if (einf) begin
			if (zr != 0) begin
				$display("[FAIL] %0t: k=%0d px=%0d expected infinity, got z=%0d",
					$time, kv, pxv, zr);
				errors++;
			end
		end else if (zr == 0) begin
			$display("[FAIL] %0t: k=%0d px=%0d unexpected infinity", $time, kv, pxv);
			errors++;
		end else begin
			ax = field_mul(xr, field_inv(zr));
			if (ax != ex) begin
				$display("[FAIL] %0t: k=%0d px=%0d expected x=%0d got x=%0d (X=%0d Z=%0d)",
					$time, kv, pxv, ex, ax, xr, zr);
				errors++;
			end
		end
	endtask

	task automatic mult_once(input scalar_t kv, input felem_t pxv, input felem_t pyv);
		felem_t xr;
		felem_t zr;
		send_req(kv, pxv);
		wait_result(0, 1'b0, '0, '0, xr, zr);
		check_mult(kv, pxv, pyv, xr, zr);
	endtask

	// Random x until x^3 + ax + b is a nonzero square
	task automatic random_point(output felem_t x, output felem_t y);
		longint rhs;
		do begin
			x = felem_t'($urandom % 32'(FIELD_P));
			rhs = (field_mul(field_mul(x, x), x) + field_mul(REF_A, x) + REF_B) % REF_P;
		end while (field_pow(rhs, (REF_P - 1) / 2) != 1);
		y = felem_t'(field_sqrt(rhs));
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors > errors_before) begin
			tests_failed++;
			$display("test %s: FAILED, %0d errors", name, errors - errors_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic test_reset_state();
		int e0;
		e0 = errors;
		@(negedge clk);
		if (in_ready !== 1'b1 || out_valid !== 1'b0) begin
			$display("[FAIL] %0t: after reset in_ready=%b out_valid=%b",
				$time, in_ready, out_valid);
			errors++;
		end
		report_test("reset_state", e0);
	endtask

	task automatic test_small_scalars();
		int     e0;
		felem_t x;
		felem_t y;
		e0 = errors;
		random_point(x, y);
		mult_once(16'd0, x, y);
		mult_once(16'd1, x, y);
		report_test("small_scalars", e0);
	endtask

	task automatic test_double_triple();
		int     e0;
		felem_t x;
		felem_t y;
		e0 = errors;
		repeat (3) begin
			random_point(x, y);
			mult_once(16'd2, x, y);
			mult_once(16'd3, x, y);
		end
		report_test("double_triple", e0);
	endtask

	task automatic test_random_scalars();
		int     e0;
		felem_t x;
		felem_t y;
		e0 = errors;
		repeat (30) begin
			random_point(x, y);
			mult_once(scalar_t'($urandom), x, y);
		end
		report_test("random_scalars", e0);
	endtask

	// Stalled output with the next request already waiting
	task automatic test_back_pressure();
		int      e0;
		int      hold;
		scalar_t k1;
		scalar_t k2;
		felem_t  x1;
		felem_t  y1;
		felem_t  x2;
		felem_t  y2;
		felem_t  xr;
		felem_t  zr;
		e0 = errors;
		random_point(x1, y1);
		random_point(x2, y2);
		k1 = scalar_t'($urandom);
		k2 = scalar_t'($urandom);
		hold = $urandom % 21;
		send_req(k1, x1);
		wait_result(hold, 1'b1, k2, x2, xr, zr);
		check_mult(k1, x1, y1, xr, zr);
		send_req(k2, x2);
		wait_result(0, 1'b0, '0, '0, xr, zr);
		check_mult(k2, x2, y2, xr, zr);
		report_test("back_pressure", e0);
	endtask

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b0;
		k = '0;
		px = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(37252));
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		test_reset_state();
		test_small_scalars();
		test_double_triple();
		test_random_scalars();
		test_back_pressure();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* hw/ladder_top.sv */
/* Ladder scalar multiplier top
   Controller, microprogram, datapath and field units */
module ladder_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               in_valid,
	output logic               in_ready,
	input  ladder_pkg::scalar_t k,
	input  ladder_pkg::felem_t px,
	output logic               out_valid,
	input  logic               out_ready,
	output ladder_pkg::felem_t x_out,
	output ladder_pkg::felem_t z_out
);
	import ladder_pkg::*;

	step_t  step;
	uword_t uword;
	logic   init;
	logic   issue;
	logic   cur_bit;

	// Arithmetic buses
	felem_t mul_a, mul_b, product;
	felem_t add_t0, add_t1, add_t2, add_t3, sum;
	felem_t sub_a, sub_b, diff;

	ladder_ctrl ctrl_i (
		.clk(clk), .rst(rst),
		.in_valid(in_valid), .in_ready(in_ready), .k(k),
		.out_valid(out_valid), .out_ready(out_ready),
		.step(step), .init(init), .issue(issue), .cur_bit(cur_bit)
	);

	ladder_ucode ucode_i (
		.step(step), .uword(uword)
	);

	ladder_datapath datapath_i (
		.clk(clk), .rst(rst),
		.init(init), .issue(issue), .cur_bit(cur_bit), .px(px), .uword(uword),
		.product(product), .sum(sum), .diff(diff),
		.mul_a(mul_a), .mul_b(mul_b),
		.add_t0(add_t0), .add_t1(add_t1), .add_t2(add_t2), .add_t3(add_t3),
		.sub_a(sub_a), .sub_b(sub_b),
		.x_out(x_out), .z_out(z_out)
	);

	mod_mul mul_i (
		.clk(clk), .rst(rst), .a(mul_a), .b(mul_b), .product(product)
	);

	mod_addsub addsub_i (
		.t0(add_t0), .t1(add_t1), .t2(add_t2), .t3(add_t3),
		.sub_a(sub_a), .sub_b(sub_b), .sum(sum), .diff(diff)
	);

endmodule

/* hw/ladder_datapath.sv */
/* Ladder datapath
   L/H pair, scratch file, operand muxes and write-back from the word */
module ladder_datapath (
	input  logic               clk,
	input  logic               rst,
	input  logic               init,
	input  logic               issue,
	input  logic               cur_bit,
	input  ladder_pkg::felem_t px,
	input  ladder_pkg::uword_t uword,
	input  ladder_pkg::felem_t product,
	input  ladder_pkg::felem_t sum,
	input  ladder_pkg::felem_t diff,
	output ladder_pkg::felem_t mul_a,
	output ladder_pkg::felem_t mul_b,
	output ladder_pkg::felem_t add_t0,
	output ladder_pkg::felem_t add_t1,
	output ladder_pkg::felem_t add_t2,
	output ladder_pkg::felem_t add_t3,
	output ladder_pkg::felem_t sub_a,
	output ladder_pkg::felem_t sub_b,
	output ladder_pkg::felem_t x_out,
	output ladder_pkg::felem_t z_out
);
	import ladder_pkg::*;

	felem_t px_q, l_x, l_z, h_x, h_z;
	felem_t r [NUM_SCRATCH];
	felem_t r_next [NUM_SCRATCH];
	felem_t src_val [2**UW_SRC_W];
	logic   upd;

	assign upd = issue && uword[UW_UPD_OFS];

	// Source table, D follows the current bit
	always_comb begin
		src_val[ZERO] = '0;
		src_val[D_X]  = cur_bit ? h_x : l_x;
		src_val[D_Z]  = cur_bit ? h_z : l_z;
		src_val[L_X]  = l_x;
		src_val[L_Z]  = l_z;
		src_val[H_X]  = h_x;
		src_val[H_Z]  = h_z;
		src_val[PX]   = px_q;
		src_val[C_A]  = CURVE_A;
		src_val[C_B]  = CURVE_B;
		src_val[C_4B] = CURVE_4B;
		for (int i = 0; i < NUM_SCRATCH; i++)
			src_val[int'(R0) + i] = r[i];
	end

	assign mul_a  = src_val[uword[UW_MUL_A_OFS +: UW_SRC_W]];
	assign mul_b  = src_val[uword[UW_MUL_B_OFS +: UW_SRC_W]];
	assign add_t0 = src_val[uword[UW_ADD_OFS +: UW_SRC_W]];
	assign add_t1 = src_val[uword[UW_ADD_OFS + UW_SRC_W +: UW_SRC_W]];
	assign add_t2 = src_val[uword[UW_ADD_OFS + 2*UW_SRC_W +: UW_SRC_W]];
	assign add_t3 = src_val[uword[UW_ADD_OFS + 3*UW_SRC_W +: UW_SRC_W]];
	assign sub_a  = src_val[uword[UW_SUB_A_OFS +: UW_SRC_W]];
	assign sub_b  = src_val[uword[UW_SUB_B_OFS +: UW_SRC_W]];

	// Write-back values, also seen by the ladder update
	always_comb begin
		for (int i = 0; i < NUM_SCRATCH; i++) begin
			case (dst_t'(uword[UW_DST_OFS + i*UW_DST_W +: UW_DST_W]))
				CLEAR:   r_next[i] = '0;
				PROD:    r_next[i] = product;
				SUM:     r_next[i] = sum;
				DIFF:    r_next[i] = diff;
				PREV:    r_next[i] = r[(i + NUM_SCRATCH - 1) % NUM_SCRATCH];
				NEXT:    r_next[i] = r[(i + 1) % NUM_SCRATCH];
				default: r_next[i] = r[i];
			endcase
		end
	end

	// px tracked until the run starts
	always_ff @(posedge clk) begin
		if (!issue && !init)
			px_q <= px;
		if (init || issue) begin
			for (int i = 0; i < NUM_SCRATCH; i++)
				r[i] <= init ? '0 : r_next[i];
		end
	end

	// Bit 1: L takes the sum, H the double; bit 0 the other way round
	always_ff @(posedge clk) begin
		if (rst) begin
			l_x <= '0;
			l_z <= '0;
			h_x <= '0;
			h_z <= '0;
		end else if (init) begin
			l_x <= 16'd1;
			l_z <= '0;
			h_x <= px_q;
			h_z <= 16'd1;
		end else if (upd) begin
			l_x <= cur_bit ? r_next[SUM_X_REG] : r_next[DBL_X_REG];
			l_z <= cur_bit ? r_next[SUM_Z_REG] : r_next[DBL_Z_REG];
			h_x <= cur_bit ? r_next[DBL_X_REG] : r_next[SUM_X_REG];
			h_z <= cur_bit ? r_next[DBL_Z_REG] : r_next[SUM_Z_REG];
		end
	end

	assign x_out = l_x;
	assign z_out = l_z;

	// Scalar bit moves only right after an update word
	a_bit_stable: assert property (@(posedge clk) disable iff (rst)
		(issue && $past(issue) && (cur_bit != $past(cur_bit))) |-> $past(upd));

endmodule

/* hw/ladder_ucode.sv */
/* Ladder microprogram
   One word per step: doubling of D and differential addition L+H */
module ladder_ucode (
	input  ladder_pkg::step_t  step,
	output ladder_pkg::uword_t uword
);
	import ladder_pkg::*;

	// Pack one word, fields in layout order
	function automatic uword_t uw(input src_t ma, mb, a0, a1, a2, a3, sa, sb,
		input dst_t d0, d1, d2, d3, d4, input logic upd);
		uword_t w;
		w = '0;
		w[UW_MUL_A_OFS +: UW_SRC_W] = ma;
		w[UW_MUL_B_OFS +: UW_SRC_W] = mb;
		w[UW_ADD_OFS +: UW_ADD_W]   = {a3, a2, a1, a0};
		w[UW_SUB_A_OFS +: UW_SRC_W] = sa;
		w[UW_SUB_B_OFS +: UW_SRC_W] = sb;
		w[UW_DST_OFS +: UW_DSTS_W]  = {d4, d3, d2, d1, d0};
		w[UW_UPD_OFS +: UW_UPD_W]   = upd;
		return w;
	endfunction

	// Product of step s is written at step s+2; a*v done as -3v
	always_comb begin
		case (step)
			// Z2, X2, XZ
			5'd0: uword = uw(D_Z, D_Z, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, KEEP, 1'b0);
			5'd1: uword = uw(D_X, D_X, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, KEEP, 1'b0);
			5'd2: uword = uw(D_X, D_Z, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, PROD, KEEP, KEEP, KEEP, KEEP, 1'b0);
			// A = XL*ZH, R2 = 3Z2
			5'd3: uword = uw(L_X, H_Z, R0, R0, R0, ZERO, ZERO, ZERO, KEEP, PROD, SUM, KEEP, KEEP, 1'b0);
			// u = 4b*Z2, g = X2-3Z2, h = X2+3Z2
			5'd4: uword = uw(C_4B, R0, R1, R0, R0, R0, R1, R2, KEEP, KEEP, DIFF, PROD, SUM, 1'b0);
			// h^2, R4 = 4XZ
			5'd5: uword = uw(R4, R4, R3, R3, R3, R3, ZERO, ZERO, KEEP, PROD, KEEP, KEEP, SUM, 1'b0);
			// 4XZ*g, then u*XZ, then u*Z2
			5'd6: uword = uw(R4, R2, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, PROD, KEEP, KEEP, 1'b0);
			5'd7: uword = uw(R2, R3, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, PROD, 1'b0);
			5'd8: uword = uw(R2, R0, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, PROD, KEEP, 1'b0);
			// B = XH*ZL
			5'd9: uword = uw(H_X, L_Z, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, PROD, KEEP, KEEP, 1'b0);
			// C = XL*XH, X' partial h^2 - w1
			5'd10: uword = uw(L_X, H_X, ZERO, ZERO, ZERO, ZERO, R4, R2, PROD, KEEP, KEEP, KEEP, DIFF, 1'b0);
			// E = ZL*ZH, doubled point lands in R2/R0
			5'd11: uword = uw(L_Z, H_Z, R3, R0, ZERO, ZERO, R4, R2, SUM, KEEP, DIFF, PROD, KEEP, 1'b0);
			// A-B and A+B
			5'd12: uword = uw(ZERO, ZERO, R1, R3, ZERO, ZERO, R1, R3, KEEP, DIFF, KEEP, SUM, PROD, 1'b0);
			// Zs = (A-B)^2
			5'd13: uword = uw(R1, R1, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, PROD, KEEP, KEEP, KEEP, 1'b0);
			// E^2, R1 = 3E
			5'd14: uword = uw(R1, R1, R1, R1, R1, ZERO, ZERO, ZERO, KEEP, SUM, KEEP, KEEP, KEEP, 1'b0);
			// C + aE
			5'd15: uword = uw(ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, R4, R1, KEEP, PROD, KEEP, KEEP, DIFF, 1'b0);
			// (A+B)(C+aE), 4b*E^2, px*Zs
			5'd16: uword = uw(R3, R4, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, PROD, KEEP, 1'b0);
			5'd17: uword = uw(C_4B, R3, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, KEEP, 1'b0);
			5'd18: uword = uw(PX, R1, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, PROD, 1'b0);
			5'd19: uword = uw(ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, PROD, KEEP, 1'b0);
			5'd20: uword = uw(ZERO, ZERO, R4, R4, R3, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, PROD, SUM, 1'b0);
			// Xs into R3, then ladder update
			5'd21: uword = uw(ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, R4, R3, KEEP, KEEP, KEEP, DIFF, CLEAR, 1'b1);
			default: uword = uw(ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, ZERO, KEEP, KEEP, KEEP, KEEP, KEEP, 1'b0);
		endcase
	end

endmodule

/* hw/ladder_ctrl.sv */
/* Ladder controller
   Handshakes, scalar shift register and the bit and step counters */
module ladder_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	output logic                in_ready,
	input  ladder_pkg::scalar_t k,
	output logic                out_valid,
	input  logic                out_ready,
	output ladder_pkg::step_t   step,
	output logic                init,
	output logic                issue,
	output logic                cur_bit
);
	import ladder_pkg::*;

	ctrl_state_t          state;
	scalar_t              k_sr;
	step_t                step_q;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic                 last_step;
	logic                 last_bit;

	assign last_step = (step_q == step_t'(STEPS_PER_BIT - 1));
	assign last_bit  = (bit_cnt == BIT_CNT_W'(SCALAR_BITS - 1));

	// Decoded from state only
	assign in_ready  = (state == IDLE);
	assign init      = (state == LOAD);
	assign issue     = (state == RUN);
	assign out_valid = (state == DONE);
	assign step      = step_q;
	// MSB first
	assign cur_bit   = k_sr[SCALAR_BITS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			step_q  <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (in_valid) begin
						state   <= LOAD;
						step_q  <= '0;
						bit_cnt <= '0;
					end
				end
				LOAD: state <= RUN;
				RUN: begin
					if (last_step) begin
						step_q  <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
							state <= DONE;
					end else begin
						step_q <= step_q + 1'b1;
					end
				end
				DONE: begin
					// Result held until taken
					if (out_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Scalar captured on acceptance, shifted after each bit
	always_ff @(posedge clk) begin
		if (in_ready && in_valid)
			k_sr <= k;
		else if (issue && last_step)
			k_sr <= k_sr << 1;
	end

	// Every scalar bit shifted out once the result is offered
	a_scalar_consumed: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> (k_sr == '0));

endmodule

/* hw/mod_addsub.sv */
/* Modular adder of four terms and modular subtractor
   Purely combinational, inputs below the prime */
module mod_addsub (
	input  ladder_pkg::felem_t t0,
	input  ladder_pkg::felem_t t1,
	input  ladder_pkg::felem_t t2,
	input  ladder_pkg::felem_t t3,
	input  ladder_pkg::felem_t sub_a,
	input  ladder_pkg::felem_t sub_b,
	output ladder_pkg::felem_t sum,
	output ladder_pkg::felem_t diff
);
	import ladder_pkg::*;

	logic [17:0] acc;
	logic [17:0] acc_lo;
	logic [16:0] dif;

	// Sum below 4p, fold by 2p then by p
	assign acc    = 18'(t0) + 18'(t1) + 18'(t2) + 18'(t3);
	assign acc_lo = (acc >= 18'(2 * FIELD_P)) ? acc - 18'(2 * FIELD_P) : acc;

	always_comb begin
		if (acc_lo >= 18'(FIELD_P))
			sum = felem_t'(acc_lo - 18'(FIELD_P));
		else
			sum = felem_t'(acc_lo);
	end

	// Borrow adds p back
	always_comb begin
		dif = 17'(sub_a) - 17'(sub_b);
		if (sub_a < sub_b)
			diff = felem_t'(dif + 17'(FIELD_P));
		else
			diff = felem_t'(dif);
	end

endmodule

/* hw/mod_mul.sv */
/* Modular multiplier, two pipeline stages
   Full product first, reduction modulo the field prime second */
module mod_mul (
	input  logic               clk,
	input  logic               rst,
	input  ladder_pkg::felem_t a,
	input  ladder_pkg::felem_t b,
	output ladder_pkg::felem_t product
);
	import ladder_pkg::*;

	dword_t prod_q;
	dword_t red;

	assign red = prod_q % dword_t'(FIELD_P);

	// New pair taken every cycle
	always_ff @(posedge clk) begin
		prod_q  <= a * b;
		product <= felem_t'(red);
	end

	// Operands arrive as reduced field elements
	a_operands_reduced: assert property (@(posedge clk) disable iff (rst)
		(a < FIELD_P) && (b < FIELD_P));

endmodule

/* hw/ladder_pkg.sv */
/* Montgomery ladder scalar multiplier
   Field, curve, microprogram word and controller definitions */
package ladder_pkg;

	// Field element and scalar widths
	typedef logic [15:0] felem_t;
	typedef logic [31:0] dword_t;
	typedef logic [15:0] scalar_t;
	typedef logic [4:0]  step_t;

	// Prime 65519, 3 mod 4
	localparam felem_t FIELD_P  = 16'd65519;
	// Curve y^2 = x^3 + a x + b with a = p - 3
	localparam felem_t CURVE_A  = 16'd65516;
	localparam felem_t CURVE_B  = 16'd7;
	localparam felem_t CURVE_4B = 16'd28;

	localparam int SCALAR_BITS   = 16;
	localparam int BIT_CNT_W     = $clog2(SCALAR_BITS);
	localparam int MUL_LATENCY   = 2;
	localparam int NUM_SCRATCH   = 5;
	localparam int NUM_ADD       = 4;
	// Words per ladder bit, fixed by the microprogram table
	localparam int STEPS_PER_BIT = 22;

	// Scratch registers holding the bit results at the update word
	localparam int DBL_X_REG = 2;
	localparam int DBL_Z_REG = 0;
	localparam int SUM_X_REG = 3;
	localparam int SUM_Z_REG = 1;

	// Operand sources, D is the point being doubled
	typedef enum logic [3:0] {
		ZERO, D_X, D_Z, L_X, L_Z, H_X, H_Z, PX,
		C_A, C_B, C_4B, R0, R1, R2, R3, R4
	} src_t;

	// Write-back per scratch register
	// PREV takes R[i-1], NEXT takes R[i+1], both wrapping
	typedef enum logic [2:0] {
		KEEP, CLEAR, PROD, SUM, DIFF, PREV, NEXT
	} dst_t;

	// Microprogram word layout
	localparam int UW_SRC_W     = 4;
	localparam int UW_DST_W     = 3;
	localparam int UW_MUL_A_OFS = 0;
	localparam int UW_MUL_B_OFS = 4;
	localparam int UW_ADD_OFS   = 8;
	localparam int UW_ADD_W     = NUM_ADD * UW_SRC_W;
	localparam int UW_SUB_A_OFS = 24;
	localparam int UW_SUB_B_OFS = 28;
	localparam int UW_DST_OFS   = 32;
	localparam int UW_DSTS_W    = NUM_SCRATCH * UW_DST_W;
	localparam int UW_UPD_OFS   = 47;
	localparam int UW_UPD_W     = 1;
	localparam int UW_WIDTH     = 48;

	typedef logic [UW_WIDTH-1:0] uword_t;

	// Controller states
	typedef enum logic [1:0] {
		IDLE, LOAD, RUN, DONE
	} ctrl_state_t;

endpackage
